//--- Bender.yml
package:
  name: mips_core

sources:
  - files:
      - src/mips_pkg.sv
      - src/pipe_if.sv
      - src/reg_file.sv
      - src/decode_stage.sv
      - src/id_ex_flopr.sv
      - src/execute_stage.sv
      - src/mips_core_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tb_checker.sv
      - verification/tb_top.sv

//--- list.f
src/mips_pkg.sv
src/pipe_if.sv
src/reg_file.sv
src/decode_stage.sv
src/id_ex_flopr.sv
src/execute_stage.sv
src/mips_core_top.sv
verification/tb_clock.sv
verification/tb_checker.sv
verification/tb_top.sv

//--- src/decode_stage.sv
`timescale 1ns/10ps

module decode_stage #(
    parameter int data_width = 32
) (
    input  logic                  instr_valid,
    input  mips_pkg::instr_t      instr,
    output mips_pkg::reg_addr_t   rf_ra1,
    output mips_pkg::reg_addr_t   rf_ra2,
    input  logic [data_width-1:0] rf_rd1,
    input  logic [data_width-1:0] rf_rd2,
    id_ex_if.source               dec
);
    typedef logic [data_width-1:0] data_t;

    mips_pkg::opcode_t   opcode;
    mips_pkg::funct_t    funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    logic [4:0]          shamt;
    logic                supported;
    logic                use_rd;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = instr[5:0];

    assign rf_ra1 = rs;
    assign rf_ra2 = rt;

    assign dec.valid    = instr_valid;
    assign dec.funct    = funct;
    assign dec.rd1      = rf_rd1;
    assign dec.rd2      = rf_rd2;
    assign dec.rs       = rs;
    assign dec.rt       = rt;
    assign dec.rd       = rd;
    assign dec.sign_imm = data_t'(signed'(instr[15:0]));
    assign dec.se_shamt = data_t'(signed'(shamt));

    ////////////////////////////////////////////////////////////////////
    // Control decode.
    always_comb
    begin
        supported        = 1'b0;
        use_rd           = 1'b0;
        dec.alu_alt_ctrl = mips_pkg::sel_funct;
        dec.b_alu_input  = 1'b0;
        dec.apply_shift  = 1'b0;
        case (opcode)
            mips_pkg::op_rtype:
            begin
                use_rd = 1'b1;
                case (funct)
                    mips_pkg::fn_sll, mips_pkg::fn_srl, mips_pkg::fn_sra:
                    begin
                        supported       = 1'b1;
                        dec.apply_shift = 1'b1;
                    end
                    mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub,
                    mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
                    mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt,
                    mips_pkg::fn_sltu:
                        supported = 1'b1;
                    default:
                        supported = 1'b0; // Unknown funct is a no-op.
                endcase
            end
            mips_pkg::op_addi, mips_pkg::op_addiu:
            begin
                supported        = 1'b1;
                dec.alu_alt_ctrl = mips_pkg::sel_add;
                dec.b_alu_input  = 1'b1;
            end
            mips_pkg::op_slti:
            begin
                supported        = 1'b1;
                dec.alu_alt_ctrl = mips_pkg::sel_slt;
                dec.b_alu_input  = 1'b1;
            end
            mips_pkg::op_sltiu:
            begin
                supported        = 1'b1;
                dec.alu_alt_ctrl = mips_pkg::sel_sltu;
                dec.b_alu_input  = 1'b1;
            end
            default:
                supported = 1'b0;
        endcase
    end

    assign dec.reg_dst_rtrd = use_rd;
    // Writes to r0 are dropped here.
    assign dec.enable_wreg  = supported && ((use_rd ? rd : rt) != mips_pkg::reg_zero);

endmodule

//--- src/execute_stage.sv
`timescale 1ns/10ps

module execute_stage #(
    parameter int data_width = 32
) (
    input  logic  clk_i,
    input  logic  reset_i,
    id_ex_if.sink ex,
    wb_if.source  wb
);
    typedef logic [data_width-1:0] data_t;

    logic                fwd_ok;
    data_t               rs_val;
    data_t               rt_val;
    data_t               alu_b;
    data_t               alu_res;
    data_t               shift_res;
    data_t               result;
    logic [4:0]          shamt;
    mips_pkg::reg_addr_t dest;

    ////////////////////////////////////////////////////////////////////
    // Operand forwarding from the writeback register.
    assign fwd_ok = wb.valid && wb.enable_wreg;
    assign rs_val = (fwd_ok && (wb.dest == ex.rs)) ? wb.data : ex.rd1;
    assign rt_val = (fwd_ok && (wb.dest == ex.rt)) ? wb.data : ex.rd2;

    assign alu_b = ex.b_alu_input ? ex.sign_imm : rt_val;
    assign shamt = ex.se_shamt[4:0];

    always_comb
    begin
        case (ex.alu_alt_ctrl)
            mips_pkg::sel_add:  alu_res = rs_val + alu_b;
            mips_pkg::sel_slt:  alu_res = data_t'($signed(rs_val) < $signed(alu_b));
            mips_pkg::sel_sltu: alu_res = data_t'(rs_val < alu_b);
            default:
            begin
                case (ex.funct)
                    mips_pkg::fn_add, mips_pkg::fn_addu:
                        alu_res = rs_val + alu_b;      // No overflow trap.
                    mips_pkg::fn_sub, mips_pkg::fn_subu:
                        alu_res = rs_val - alu_b;
                    mips_pkg::fn_and:  alu_res = rs_val & alu_b;
                    mips_pkg::fn_or:   alu_res = rs_val | alu_b;
                    mips_pkg::fn_xor:  alu_res = rs_val ^ alu_b;
                    mips_pkg::fn_nor:  alu_res = ~(rs_val | alu_b);
                    mips_pkg::fn_slt:
                        alu_res = data_t'($signed(rs_val) < $signed(alu_b));
                    mips_pkg::fn_sltu:
                        alu_res = data_t'(rs_val < alu_b);
                    default: alu_res = '0;
                endcase
            end
        endcase
    end

    // Shifts act on rt.
    always_comb
    begin
        case (ex.funct)
            mips_pkg::fn_srl: shift_res = rt_val >> shamt;
            mips_pkg::fn_sra: shift_res = $signed(rt_val) >>> shamt;
            default:          shift_res = rt_val << shamt;
        endcase
    end

    assign result = ex.apply_shift ? shift_res : alu_res;
    assign dest   = ex.reg_dst_rtrd ? ex.rd : ex.rt;

    ////////////////////////////////////////////////////////////////////
    // Writeback register.
    always_ff @(posedge clk_i, posedge reset_i)
    begin
        if (reset_i)
        begin
            wb.valid       <= 1'b0;
            wb.enable_wreg <= 1'b0;
        end
        else
        begin
            wb.valid       <= ex.valid;
            wb.enable_wreg <= ex.enable_wreg;
        end
    end

    always_ff @(posedge clk_i)
    begin
        wb.dest <= dest;
        wb.data <= result;
    end

endmodule

//--- src/id_ex_flopr.sv
`timescale 1ns/10ps

module id_ex_flopr #(
    parameter int data_width = 32
) (
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   flush,
    id_ex_if.sink   id,
    id_ex_if.source ex
);
    localparam logic [data_width-1:0] zero_word = '0;

    always_ff @(posedge clk_i, posedge reset_i)
    begin
        if (reset_i)
        begin
            ex.valid        <= 1'b0;
            ex.funct        <= '0;
            ex.rd1          <= zero_word;
            ex.rd2          <= zero_word;
            ex.rs           <= '0;
            ex.rt           <= '0;
            ex.rd           <= '0;
            ex.sign_imm     <= zero_word;
            ex.se_shamt     <= zero_word;
            ex.enable_wreg  <= 1'b0;
            ex.alu_alt_ctrl <= mips_pkg::sel_funct;
            ex.b_alu_input  <= 1'b0;
            ex.apply_shift  <= 1'b0;
            ex.reg_dst_rtrd <= 1'b0;
        end
        else if (flush)             // Bubble.
        begin
            ex.valid        <= 1'b0;
            ex.funct        <= '0;
            ex.rd1          <= zero_word;
            ex.rd2          <= zero_word;
            ex.rs           <= '0;
            ex.rt           <= '0;
            ex.rd           <= '0;
            ex.sign_imm     <= zero_word;
            ex.se_shamt     <= zero_word;
            ex.enable_wreg  <= 1'b0;
            ex.alu_alt_ctrl <= mips_pkg::sel_funct;
            ex.b_alu_input  <= 1'b0;
            ex.apply_shift  <= 1'b0;
            ex.reg_dst_rtrd <= 1'b0;
        end
        else
        begin
            ex.valid        <= id.valid;
            ex.funct        <= id.funct;
            ex.rd1          <= id.rd1;
            ex.rd2          <= id.rd2;
            ex.rs           <= id.rs;
            ex.rt           <= id.rt;
            ex.rd           <= id.rd;
            ex.sign_imm     <= id.sign_imm;
            ex.se_shamt     <= id.se_shamt;
            ex.enable_wreg  <= id.enable_wreg;
            ex.alu_alt_ctrl <= id.alu_alt_ctrl;
            ex.b_alu_input  <= id.b_alu_input;
            ex.apply_shift  <= id.apply_shift;
            ex.reg_dst_rtrd <= id.reg_dst_rtrd;
        end
    end

endmodule

//--- src/mips_core_top.sv
`timescale 1ns/10ps

module mips_core_top #(
    parameter int data_width = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  instr_valid,
    input  mips_pkg::instr_t      instr,
    input  logic                  flush,
    output logic                  wb_valid,
    output mips_pkg::reg_addr_t   wb_reg,
    output logic [data_width-1:0] wb_data
);
    mips_pkg::reg_addr_t   rf_ra1;
    mips_pkg::reg_addr_t   rf_ra2;
    logic [data_width-1:0] rf_rd1;
    logic [data_width-1:0] rf_rd2;

    id_ex_if #(.data_width(data_width)) dec_bus ();
    id_ex_if #(.data_width(data_width)) ex_bus ();
    wb_if    #(.data_width(data_width)) wb_bus ();

    ////////////////////////////////////////////////////////////////////
    // Decode and register read.
    decode_stage #(.data_width(data_width)) decode_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rf_ra1      (rf_ra1),
        .rf_ra2      (rf_ra2),
        .rf_rd1      (rf_rd1),
        .rf_rd2      (rf_rd2),
        .dec         (dec_bus.source)
    );

    reg_file #(.data_width(data_width)) reg_file_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .ra1     (rf_ra1),
        .ra2     (rf_ra2),
        .rd1     (rf_rd1),
        .rd2     (rf_rd2),
        .wb      (wb_bus.sink)
    );

    ////////////////////////////////////////////////////////////////////
    // Pipeline register and execute.
    id_ex_flopr #(.data_width(data_width)) id_ex_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .flush   (flush),
        .id      (dec_bus.sink),
        .ex      (ex_bus.source)
    );

    execute_stage #(.data_width(data_width)) execute_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .ex      (ex_bus.sink),
        .wb      (wb_bus.source)
    );

    assign wb_valid = wb_bus.valid & wb_bus.enable_wreg; // Register writes only.
    assign wb_reg   = wb_bus.dest;
    assign wb_data  = wb_bus.data;

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [5:0]  funct_t;
    typedef logic [5:0]  opcode_t;

    // I-type ALU selection; R-types defer to the funct field.
    typedef enum logic [1:0] {
        sel_funct,
        sel_add,
        sel_slt,
        sel_sltu
    } alu_sel_t;

    localparam reg_addr_t reg_zero = 5'd0;

    ////////////////////////////////////////////////////////////////////
    // Primary opcodes.
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_addi  = 6'h08;
    localparam opcode_t op_addiu = 6'h09;
    localparam opcode_t op_slti  = 6'h0a;
    localparam opcode_t op_sltiu = 6'h0b;

    ////////////////////////////////////////////////////////////////////
    // R-type function codes.
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_sra  = 6'h03;
    localparam funct_t fn_add  = 6'h20;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_sub  = 6'h22;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;

endpackage

//--- src/pipe_if.sv
`timescale 1ns/10ps

// Decoded instruction bundle between decode and execute.
interface id_ex_if #(
    parameter int data_width = 32
);
    logic                  valid;
    mips_pkg::funct_t      funct;
    logic [data_width-1:0] rd1;
    logic [data_width-1:0] rd2;
    mips_pkg::reg_addr_t   rs;
    mips_pkg::reg_addr_t   rt;
    mips_pkg::reg_addr_t   rd;
    logic [data_width-1:0] sign_imm;
    logic [data_width-1:0] se_shamt;
    logic                  enable_wreg;
    mips_pkg::alu_sel_t    alu_alt_ctrl;
    logic                  b_alu_input;  // Immediate as operand B.
    logic                  apply_shift;
    logic                  reg_dst_rtrd; // High selects rd.

    modport source (output valid, funct, rd1, rd2, rs, rt, rd, sign_imm, se_shamt,
                    enable_wreg, alu_alt_ctrl, b_alu_input, apply_shift, reg_dst_rtrd);
    modport sink (input valid, funct, rd1, rd2, rs, rt, rd, sign_imm, se_shamt,
                  enable_wreg, alu_alt_ctrl, b_alu_input, apply_shift, reg_dst_rtrd);
endinterface

// Writeback result.
interface wb_if #(
    parameter int data_width = 32
);
    logic                  valid;
    mips_pkg::reg_addr_t   dest;
    logic [data_width-1:0] data;
    logic                  enable_wreg;

    modport source (output valid, dest, data, enable_wreg);
    modport sink (input valid, dest, data, enable_wreg);
endinterface

//--- src/reg_file.sv
`timescale 1ns/10ps

module reg_file #(
    parameter int data_width = 32
) (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  mips_pkg::reg_addr_t   ra1,
    input  mips_pkg::reg_addr_t   ra2,
    output logic [data_width-1:0] rd1,
    output logic [data_width-1:0] rd2,
    wb_if.sink                    wb
);
    typedef logic [data_width-1:0] data_t;

    data_t               regs [1:31]; // r0 has no storage.
    logic                wr_en;
    mips_pkg::reg_addr_t wr_dest;
    data_t               wr_data;

    assign wr_en   = wb.valid && wb.enable_wreg && (wb.dest != mips_pkg::reg_zero);
    assign wr_dest = wb.dest;
    assign wr_data = wb.data;

    always_ff @(posedge clk_i, posedge reset_i)
    begin
        if (reset_i)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
            regs[wr_dest] <= wr_data;
    end

    // Write data bypasses the array on a same-cycle read.
    assign rd1 = (ra1 == mips_pkg::reg_zero)    ? '0      :
                 (wr_en && (wr_dest == ra1))    ? wr_data : regs[ra1];
    assign rd2 = (ra2 == mips_pkg::reg_zero)    ? '0      :
                 (wr_en && (wr_dest == ra2))    ? wr_data : regs[ra2];

endmodule

//--- verification/tb_checker.sv
`timescale 1ns/10ps

module tb_checker #(
    parameter int data_width = 32
) (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  instr_valid,
    input logic [31:0]           instr,
    input logic                  flush,
    input logic                  wb_valid,
    input logic [4:0]            wb_reg,
    input logic [data_width-1:0] wb_data
);
    typedef logic [data_width-1:0] data_t;

    data_t      model_regs [32];
    logic [4:0] exp_reg [$];
    data_t      exp_data [$];
    string      test_name;
    int         test_errors;
    int         total_errors;
    int         tests_run;
    int         tests_failed;

    initial
    begin
        test_name    = "idle";
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
    end

    // Sequential model of one instruction; returns 1 when a nonzero register is written.
    function automatic logic execute_instr(input logic [31:0] word, input data_t a,
                                           input data_t b, output logic [4:0] dest,
                                           output data_t value);
        logic [5:0]  op;
        logic [5:0]  fn;
        int unsigned sh;
        data_t       imm;
        logic        writes;
        op     = word[31:26];
        fn     = word[5:0];
        sh     = word[10:6];
        imm    = {{(data_width-16){word[15]}}, word[15:0]};
        dest   = (op == mips_pkg::op_rtype) ? word[15:11] : word[20:16];
        value  = '0;
        writes = 1'b1;
        case (op)
            mips_pkg::op_rtype:
            begin
                case (fn)
                    mips_pkg::fn_add, mips_pkg::fn_addu: value = a + b;
                    mips_pkg::fn_sub, mips_pkg::fn_subu: value = a - b;
                    mips_pkg::fn_and:  value = a & b;
                    mips_pkg::fn_or:   value = a | b;
                    mips_pkg::fn_xor:  value = a ^ b;
                    mips_pkg::fn_nor:  value = ~(a | b);
                    mips_pkg::fn_slt:  value = ($signed(a) < $signed(b)) ? 1 : 0;
                    mips_pkg::fn_sltu: value = (a < b) ? 1 : 0;
                    mips_pkg::fn_sll:  value = b << sh;
                    mips_pkg::fn_srl:  value = b >> sh;
                    mips_pkg::fn_sra:  value = $signed(b) >>> sh;
                    default:           writes = 1'b0;
                endcase
            end
            mips_pkg::op_addi, mips_pkg::op_addiu: value = a + imm;
            mips_pkg::op_slti:  value = ($signed(a) < $signed(imm)) ? 1 : 0;
            mips_pkg::op_sltiu: value = (a < imm) ? 1 : 0;
            default:            writes = 1'b0;
        endcase
        return writes && (dest != 5'd0);
    endfunction

    function automatic int pending();
        return exp_reg.size();
    endfunction

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test(input string name);
        if (exp_reg.size() != 0)
        begin
            $display("test %s: %0d expected writebacks never appeared", name, exp_reg.size());
            test_errors++;
            exp_reg.delete();
            exp_data.delete();
        end
        if (test_errors == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, test_errors);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        total_errors += test_errors;
    endtask

    task automatic report_totals();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare at the falling edge, where inputs and outputs are settled.
    always @(negedge clk_i)
    begin
        logic [4:0] dest;
        data_t      value;
        logic       writes;
        logic [4:0] want_reg;
        data_t      want_data;
        if (!reset_i)
        begin
            if (wb_valid)
            begin
                if (exp_reg.size() == 0)
                begin
                    $display("test %s: writeback to r%0d arrived with nothing pending",
                             test_name, wb_reg);
                    test_errors++;
                end
                else
                begin
                    want_reg  = exp_reg.pop_front();
                    want_data = exp_data.pop_front();
                    if (want_reg !== wb_reg || want_data !== wb_data)
                    begin
                        $display("ERROR test %s: expected r%0d = %h, actual r%0d = %h",
                                 test_name, want_reg, want_data, wb_reg, wb_data);
                        test_errors++;
                    end
                end
            end
            if (instr_valid && !flush)
            begin
                writes = execute_instr(instr, model_regs[instr[25:21]],
                                       model_regs[instr[20:16]], dest, value);
                if (writes)
                begin
                    model_regs[dest] = value;
                    exp_reg.push_back(dest);
                    exp_data.push_back(value);
                end
            end
        end
    end

endmodule

//--- verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk_i,
    output logic reset_i
);
    initial
    begin
        clk_i   = 1'b0;
        reset_i = 1'b1;
        repeat (16) @(posedge clk_i);
        #2 reset_i = 1'b0; // Released clear of the edge.
    end

    always #20 clk_i = ~clk_i; // 40 ns period.

endmodule

//--- verification/tb_top.sv
`timescale 1ns/10ps

module tb_top;
    localparam int data_width = 32;

    logic                  clk_i;
    logic                  reset_i;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  flush;
    logic                  wb_valid;
    logic [4:0]            wb_reg;
    logic [data_width-1:0] wb_data;
    logic [5:0]            r_functs [13];
    logic [5:0]            i_opcodes [4];

    tb_clock clk_gen_i (
        .clk_i   (clk_i),
        .reset_i (reset_i)
    );

    mips_core_top #(.data_width(data_width)) dut_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

    tb_checker #(.data_width(data_width)) chk_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .instr_valid (instr_valid),
        .instr       (instr),
        .flush       (flush),
        .wb_valid    (wb_valid),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data)
    );

    function automatic logic [31:0] encode_r(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
        return {mips_pkg::op_rtype, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Registers are drawn from r0..top_reg so that small ranges give dependencies.
    function automatic logic [31:0] random_op(input int unsigned top_reg);
        int unsigned pick;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        pick = $urandom_range(16);
        rs   = 5'($urandom_range(top_reg));
        rt   = 5'($urandom_range(top_reg));
        rd   = 5'($urandom_range(top_reg));
        if (pick < 13)
            return encode_r(r_functs[pick], rs, rt, rd, 5'($urandom));
        else
            return encode_i(i_opcodes[pick-13], rs, rt, 16'($urandom));
    endfunction

    task automatic drive(input logic valid, input logic [31:0] word, input logic kill);
        @(posedge clk_i);
        #2;
        instr_valid = valid;
        instr       = word;
        flush       = kill;
    endtask

    task automatic drain(input string name);
        drive(1'b0, 32'h0, 1'b0);
        for (int n = 0; n < 40; n++)
        begin
            @(posedge clk_i);
            if (n >= 3 && chk_i.pending() == 0)
                break;
        end
        chk_i.end_test(name);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests.
    task automatic test_reset_state();
        chk_i.start_test("reset_state");
        for (int r = 1; r < 32; r++)
            drive(1'b1, encode_r(mips_pkg::fn_add, 5'(r), 5'd0, 5'(r), 5'd0), 1'b0);
        drain("reset_state");
    endtask

    task automatic test_sign_ext();
        chk_i.start_test("sign_ext");
        for (int i = 0; i < 32; i++)
        begin
            drive(1'b1, encode_i(i_opcodes[$urandom_range(3)], 5'($urandom),
                                 5'($urandom), 16'($urandom)), 1'b0);
            drive(1'b0, 32'h0, 1'b0);
        end
        drain("sign_ext");
    endtask

    task automatic test_rtype();
        chk_i.start_test("rtype_ops");
        for (int k = 0; k < 39; k++)
        begin
            drive(1'b1, encode_r(r_functs[k % 13], 5'($urandom), 5'($urandom),
                                 5'($urandom_range(31, 1)), 5'($urandom)), 1'b0);
            repeat (3) drive(1'b0, 32'h0, 1'b0); // Operands settle in the register file.
        end
        drain("rtype_ops");
    endtask

    task automatic test_forwarding();
        chk_i.start_test("forwarding");
        for (int i = 0; i < 80; i++)
        begin
            drive(1'b1, random_op(4), 1'b0);
            if ($urandom_range(3) == 0)
                repeat ($urandom_range(2, 1)) drive(1'b0, $urandom, 1'b0);
        end
        drain("forwarding");
    endtask

    task automatic test_flush();
        chk_i.start_test("flush");
        for (int i = 0; i < 48; i++)
            drive(1'b1, random_op(4), $urandom_range(3) == 0);
        drain("flush");
    endtask

    task automatic test_no_write();
        logic [31:0] word;
        chk_i.start_test("no_write");
        for (int i = 0; i < 48; i++)
        begin
            word = random_op(5);
            case ($urandom_range(3))
                0:
                begin
                    if (word[31:26] == mips_pkg::op_rtype)
                        word[15:11] = mips_pkg::reg_zero;
                    else
                        word[20:16] = mips_pkg::reg_zero;
                end
                1: word[31:26] = 6'h20 | 6'($urandom_range(15)); // Loads and stores.
                2: word = {mips_pkg::op_rtype, word[25:6], 6'h08 | 6'($urandom_range(7))};
                default: ;
            endcase
            drive(1'b1, word, 1'b0);
        end
        drain("no_write");
    endtask

    initial
    begin
        int n;
        void'($urandom(32'h669d));
        instr_valid  = 1'b0;
        instr        = 32'h0;
        flush        = 1'b0;
        r_functs     = '{mips_pkg::fn_add, mips_pkg::fn_addu, mips_pkg::fn_sub,
                         mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
                         mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt,
                         mips_pkg::fn_sltu, mips_pkg::fn_sll, mips_pkg::fn_srl,
                         mips_pkg::fn_sra};
        i_opcodes    = '{mips_pkg::op_addi, mips_pkg::op_addiu, mips_pkg::op_slti,
                         mips_pkg::op_sltiu};
        for (n = 0; n < 64 && reset_i !== 1'b0; n++)
            @(posedge clk_i);
        if (reset_i !== 1'b0)
        begin
            $display("reset was never released");
            $display("TB FAILED");
        end
        else
        begin
            test_reset_state();
            test_sign_ext();
            test_rtype();
            test_forwarding();
            test_flush();
            test_no_write();
            chk_i.report_totals();
            if (chk_i.total_errors == 0)
                $display("TB PASSED");
            else
                $display("TB FAILED");
        end
        $finish;
    end

endmodule
